/* Bender.yml */
package:
  name: bch_decoder

sources:
  - include_dirs:
      - include
    files:
      - rtl/bch_pkg.sv
      - rtl/bch_syndrome_calc.sv
      - rtl/bch_sigma_bma.sv
      - rtl/bch_chien_search.sv
      - rtl/bch_codeword_buffer.sv
      - rtl/bch_error_corrector.sv
      - rtl/bch_decoder.sv
      - target: simulation
        files:
          - sim/bch_decoder_tb.sv

/* flist.f */
+incdir+include
rtl/bch_pkg.sv
rtl/bch_syndrome_calc.sv
rtl/bch_sigma_bma.sv
rtl/bch_chien_search.sv
rtl/bch_codeword_buffer.sv
rtl/bch_error_corrector.sv
rtl/bch_decoder.sv
sim/bch_decoder_tb.sv

/* include/bch_defines.svh */
`ifndef BCH_DEFINES_SVH
`define BCH_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Code parameters for binary BCH (15,7), t = 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Width of one GF(2^m) element
`define BCH_M 4

// Code length n = 2^m - 1
`define BCH_N 15

// Number of data bits per codeword
`define BCH_K 7

// Number of correctable bit errors
`define BCH_T 2

// Field polynomial x^4 + x + 1
`define BCH_FIELD_POLY 5'b10011

// Generator polynomial x^8 + x^7 + x^6 + x^4 + 1
`define BCH_GEN_POLY 9'b111010001

`endif

/* rtl/bch_chien_search.sv */
`timescale 1ns/100ps

`include "bch_defines.svh"

module bch_chien_search (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  bch_pkg::sigma_t   sigma,
	input  bch_pkg::err_cnt_t err_count,
	output logic              mask_valid,
	output logic [`BCH_N-1:0] err_mask,
	output bch_pkg::err_cnt_t root_count,
	output bch_pkg::err_cnt_t err_count_out
);

	localparam bch_pkg::gf_elem_t ALPHA1 = 4'h2;
	localparam bch_pkg::gf_elem_t ALPHA2 = 4'h4;

	bch_pkg::gf_elem_t term [3];
	logic [3:0]        pos_cnt;
	logic              busy;
	logic              root;

	// Terms hold sigma_i * alpha^(i*c), their sum is sigma(alpha^c)
	assign root = (term[0] ^ term[1] ^ term[2]) == '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			mask_valid <= 1'b0;
			pos_cnt    <= '0;
		end else begin
			mask_valid <= 1'b0;
			if (start) begin
				busy    <= 1'b1;
				pos_cnt <= '0;
			end else if (busy) begin
				pos_cnt <= pos_cnt + 4'd1;
				if (pos_cnt == 4'(`BCH_N - 1)) begin
					busy       <= 1'b0;
					mask_valid <= 1'b1;
				end
			end
		end
	end

	// A root at alpha^c marks an error at bit 15 - c, so c = 1 lands in bit 14
	always_ff @(posedge clk) begin
		if (start) begin
			term[0]       <= sigma.sig0;
			term[1]       <= bch_pkg::gf_mul(sigma.sig1, ALPHA1);
			term[2]       <= bch_pkg::gf_mul(sigma.sig2, ALPHA2);
			err_mask      <= '0;
			root_count    <= '0;
			err_count_out <= err_count;
		end else if (busy) begin
			term[1]  <= bch_pkg::gf_mul(term[1], ALPHA1);
			term[2]  <= bch_pkg::gf_mul(term[2], ALPHA2);
			err_mask <= {err_mask[`BCH_N-2:0], root};
			if (root && root_count != bch_pkg::ERR_UNCORR)
				root_count <= root_count + 2'd1;
		end
	end

endmodule

/* rtl/bch_codeword_buffer.sv */
`timescale 1ns/100ps

`include "bch_defines.svh"

module bch_codeword_buffer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  logic [`BCH_N-1:0] rx_word,
	input  logic              release_word,
	output logic [`BCH_N-1:0] held_word
);

	logic held;

	// Tracks whether a word is still waiting for the corrector
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			held <= 1'b0;
		end else begin
			if (start)
				held <= 1'b1;
			else if (release_word)
				held <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			held_word <= rx_word;
	end

	// A new word may only land once the corrector has consumed the old one
	assert property (@(posedge clk) disable iff (!rst_n) start |-> !held)
		else $error("bch_codeword_buffer: word overwritten before release");

endmodule

/* rtl/bch_decoder.sv */
`timescale 1ns/100ps

`include "bch_defines.svh"

module bch_decoder (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic [`BCH_N-1:0]    rx_word,
	input  logic                 ack_done,
	output logic                 ready,
	output logic                 done,
	output bch_pkg::dec_result_t result
);

	logic                syn_valid;
	bch_pkg::syndromes_t syndromes;
	logic                sigma_valid;
	bch_pkg::sigma_t     sigma;
	bch_pkg::err_cnt_t   bma_err_count;
	logic                mask_valid;
	logic [`BCH_N-1:0]   err_mask;
	bch_pkg::err_cnt_t   root_count;
	bch_pkg::err_cnt_t   chien_err_count;
	logic [`BCH_N-1:0]   held_word;
	logic                release_word;

	bch_codeword_buffer bch_codeword_buffer_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.rx_word      (rx_word),
		.release_word (release_word),
		.held_word    (held_word)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Locator path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	bch_syndrome_calc bch_syndrome_calc_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.rx_word   (rx_word),
		.syn_valid (syn_valid),
		.syndromes (syndromes)
	);

	bch_sigma_bma bch_sigma_bma_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (syn_valid),
		.syndromes   (syndromes),
		.sigma_valid (sigma_valid),
		.sigma       (sigma),
		.err_count   (bma_err_count)
	);

	bch_chien_search bch_chien_search_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (sigma_valid),
		.sigma         (sigma),
		.err_count     (bma_err_count),
		.mask_valid    (mask_valid),
		.err_mask      (err_mask),
		.root_count    (root_count),
		.err_count_out (chien_err_count)
	);

	bch_error_corrector bch_error_corrector_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.mask_valid   (mask_valid),
		.err_mask     (err_mask),
		.root_count   (root_count),
		.err_count    (chien_err_count),
		.held_word    (held_word),
		.ack_done     (ack_done),
		.release_word (release_word),
		.ready        (ready),
		.done         (done),
		.result       (result)
	);

endmodule

/* rtl/bch_error_corrector.sv */
`timescale 1ns/100ps

`include "bch_defines.svh"

module bch_error_corrector (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic                 mask_valid,
	input  logic [`BCH_N-1:0]    err_mask,
	input  bch_pkg::err_cnt_t    root_count,
	input  bch_pkg::err_cnt_t    err_count,
	input  logic [`BCH_N-1:0]    held_word,
	input  logic                 ack_done,
	output logic                 release_word,
	output logic                 ready,
	output logic                 done,
	output bch_pkg::dec_result_t result
);

	logic              busy;
	logic              active;
	logic              uncorr;
	logic [`BCH_N-1:0] fixed_word;

	// Fewer roots than the locator degree means the errors lie outside the code
	assign uncorr     = (err_count == bch_pkg::ERR_UNCORR) || (root_count != err_count);
	assign fixed_word = uncorr ? held_word : (held_word ^ err_mask);

	// The buffer is free again as soon as the result register takes the word
	assign release_word = mask_valid;

	assign ready = active && !busy && (!done || ack_done);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			busy   <= 1'b0;
			done   <= 1'b0;
		end else begin
			active <= 1'b1;
			if (start)
				busy <= 1'b1;
			else if (mask_valid)
				busy <= 1'b0;
			if (mask_valid)
				done <= 1'b1;
			else if (ack_done)
				done <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (mask_valid) begin
			result.codeword      <= fixed_word;
			result.data          <= fixed_word[`BCH_N-1 -: `BCH_K];
			result.err_count     <= err_count;
			result.uncorrectable <= uncorr;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) start |-> ready)
		else $error("bch_error_corrector: start while not ready");

	assert property (@(posedge clk) disable iff (!rst_n) done && !ack_done |=> done && $stable(result))
		else $error("bch_error_corrector: result changed before ack_done");

endmodule

/* rtl/bch_pkg.sv */
`include "bch_defines.svh"

package bch_pkg;

	localparam int M = `BCH_M;
	localparam logic [M:0] FIELD_POLY = `BCH_FIELD_POLY;

	typedef logic [M-1:0] gf_elem_t;

	// Error count, where 3 always means more errors than the code can fix
	typedef logic [1:0] err_cnt_t;

	localparam err_cnt_t ERR_UNCORR = 2'd3;

	typedef struct packed {
		gf_elem_t s1;
		gf_elem_t s2;
		gf_elem_t s3;
		gf_elem_t s4;
	} syndromes_t;

	// Locator polynomial sig0 + sig1*x + sig2*x^2
	typedef struct packed {
		gf_elem_t sig0;
		gf_elem_t sig1;
		gf_elem_t sig2;
	} sigma_t;

	typedef struct packed {
		logic [`BCH_N-1:0] codeword;
		logic [`BCH_K-1:0] data;
		err_cnt_t          err_count;
		logic              uncorrectable;
	} dec_result_t;

	// Shift-and-add multiply, reducing by the field polynomial on each shift
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < M; i++) begin
			if (b[i])
				acc = acc ^ sh;
			sh = sh[M-1] ? ((sh << 1) ^ FIELD_POLY[M-1:0]) : (sh << 1);
		end
		return acc;
	endfunction

endpackage

/* rtl/bch_sigma_bma.sv */
`timescale 1ns/100ps

`include "bch_defines.svh"

module bch_sigma_bma (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  bch_pkg::syndromes_t syndromes,
	output logic                sigma_valid,
	output bch_pkg::sigma_t     sigma,
	output bch_pkg::err_cnt_t   err_count
);

	bch_pkg::gf_elem_t sig_c [3];
	bch_pkg::gf_elem_t beta [3];
	bch_pkg::gf_elem_t syn_win [3];
	bch_pkg::gf_elem_t syn_queue [3];
	bch_pkg::gf_elem_t d_r;
	bch_pkg::gf_elem_t d_p;
	bch_pkg::gf_elem_t d_comb;
	bch_pkg::gf_elem_t scale;
	bch_pkg::err_cnt_t len;
	bch_pkg::err_cnt_t iter;
	bch_pkg::err_cnt_t len_new;
	logic [1:0]        step;
	logic              upd_phase;
	logic              busy;
	logic              bsel;

	// Inverse lookup for x^4 + x + 1 where zero maps to zero
	function automatic bch_pkg::gf_elem_t gf_inv(input bch_pkg::gf_elem_t a);
		bch_pkg::gf_elem_t r;
		case (a)
			4'h1: r = 4'h1;
			4'h2: r = 4'h9;
			4'h3: r = 4'he;
			4'h4: r = 4'hd;
			4'h5: r = 4'hb;
			4'h6: r = 4'h7;
			4'h7: r = 4'h6;
			4'h8: r = 4'hf;
			4'h9: r = 4'h2;
			4'ha: r = 4'hc;
			4'hb: r = 4'h5;
			4'hc: r = 4'ha;
			4'hd: r = 4'h4;
			4'he: r = 4'h3;
			4'hf: r = 4'h8;
			default: r = 4'h0;
		endcase
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Discrepancy and correction term
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// d_r is the sum of sigma_i * S_(n+1-i)
	// The window holds S_(n+1) down to S_(n-1)
	assign d_comb = bch_pkg::gf_mul(sig_c[0], syn_win[0]) ^
		bch_pkg::gf_mul(sig_c[1], syn_win[1]) ^
		bch_pkg::gf_mul(sig_c[2], syn_win[2]);

	assign scale = bch_pkg::gf_mul(d_r, gf_inv(d_p));

	// Iteration index r is half the step number, since odd steps carry no discrepancy
	assign iter    = {1'b0, step[1]};
	assign bsel    = (d_r != '0) && (iter >= len);
	assign len_new = (iter << 1) + 2'd1 - len;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy        <= 1'b0;
			sigma_valid <= 1'b0;
			upd_phase   <= 1'b0;
			step        <= '0;
			len         <= '0;
		end else begin
			sigma_valid <= 1'b0;
			if (start) begin
				busy      <= 1'b1;
				upd_phase <= 1'b0;
				step      <= '0;
				len       <= '0;
			end else if (busy) begin
				upd_phase <= !upd_phase;
				if (upd_phase) begin
					step <= step + 2'd1;
					if (bsel)
						len <= len_new;
					if (step == 2'(2 * `BCH_T - 1)) begin
						busy        <= 1'b0;
						sigma_valid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			sig_c        <= '{4'h1, 4'h0, 4'h0};
			beta         <= '{4'h0, 4'h1, 4'h0};
			d_p          <= 4'h1;
			syn_win      <= '{syndromes.s1, 4'h0, 4'h0};
			syn_queue    <= '{syndromes.s2, syndromes.s3, syndromes.s4};
		end else if (busy && !upd_phase) begin
			// Odd steps of a binary code always have a zero discrepancy
			d_r <= step[0] ? '0 : d_comb;
		end else if (busy) begin
			for (int i = 0; i < 3; i++)
				sig_c[i] <= sig_c[i] ^ bch_pkg::gf_mul(scale, beta[i]);
			// Beta becomes x*sigma on a length change, else it just moves up by x.
			// It enters step 2 as x^2 when S1 is nonzero. With S1 zero it would be x^3,
			// which lies past the top locator coefficient and drops out.
			if (bsel) begin
				beta <= '{4'h0, sig_c[0], sig_c[1]};
				d_p  <= d_r;
			end else begin
				beta <= '{4'h0, beta[0], beta[1]};
			end
			syn_win   <= '{syn_queue[0], syn_win[0], syn_win[1]};
			syn_queue <= '{syn_queue[1], syn_queue[2], 4'h0};
			if (step == 2'(2 * `BCH_T - 1))
				err_count <= (len > bch_pkg::err_cnt_t'(`BCH_T)) ? bch_pkg::ERR_UNCORR : len;
		end
	end

	assign sigma = '{sig0: sig_c[0], sig1: sig_c[1], sig2: sig_c[2]};

	assert property (@(posedge clk) disable iff (!rst_n) busy |-> !start)
		else $error("bch_sigma_bma: start while solver is iterating");

	// Beta always carries a factor of x, so the constant term never moves
	assert property (@(posedge clk) disable iff (!rst_n) sigma_valid |-> sigma.sig0 == 4'h1)
		else $error("bch_sigma_bma: sig0 lost its value of one");

endmodule

/* rtl/bch_syndrome_calc.sv */
`timescale 1ns/100ps

`include "bch_defines.svh"

module bch_syndrome_calc (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  logic [`BCH_N-1:0]   rx_word,
	output logic                syn_valid,
	output bch_pkg::syndromes_t syndromes
);

	localparam bch_pkg::gf_elem_t ALPHA1 = 4'h2;
	localparam bch_pkg::gf_elem_t ALPHA2 = 4'h4;
	localparam bch_pkg::gf_elem_t ALPHA3 = 4'h8;
	localparam bch_pkg::gf_elem_t ALPHA4 = 4'h3;

	logic [`BCH_N-1:0] shift_q;
	logic [3:0]        bit_cnt;
	logic              running;
	logic              top_bit;
	bch_pkg::gf_elem_t bit_elem;

	// The highest bit goes in first, straight from rx_word in the start cycle
	assign top_bit  = start ? rx_word[`BCH_N-1] : shift_q[`BCH_N-1];
	assign bit_elem = {{(`BCH_M-1){1'b0}}, top_bit};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running   <= 1'b0;
			syn_valid <= 1'b0;
			bit_cnt   <= '0;
		end else begin
			syn_valid <= 1'b0;
			if (start) begin
				running <= 1'b1;
				bit_cnt <= 4'd1;
			end else if (running) begin
				bit_cnt <= bit_cnt + 4'd1;
				if (bit_cnt == 4'(`BCH_N - 1)) begin
					running   <= 1'b0;
					syn_valid <= 1'b1;
				end
			end
		end
	end

	// Horner step: S_j <= S_j * alpha^j + r_i
	always_ff @(posedge clk) begin
		if (start) begin
			shift_q      <= {rx_word[`BCH_N-2:0], 1'b0};
			syndromes.s1 <= bit_elem;
			syndromes.s2 <= bit_elem;
			syndromes.s3 <= bit_elem;
			syndromes.s4 <= bit_elem;
		end else if (running) begin
			shift_q      <= {shift_q[`BCH_N-2:0], 1'b0};
			syndromes.s1 <= bch_pkg::gf_mul(syndromes.s1, ALPHA1) ^ bit_elem;
			syndromes.s2 <= bch_pkg::gf_mul(syndromes.s2, ALPHA2) ^ bit_elem;
			syndromes.s3 <= bch_pkg::gf_mul(syndromes.s3, ALPHA3) ^ bit_elem;
			syndromes.s4 <= bch_pkg::gf_mul(syndromes.s4, ALPHA4) ^ bit_elem;
		end
	end

endmodule

/* sim/bch_decoder_tb.sv */
`timescale 1ns/100ps

`include "bch_defines.svh"

module bch_decoder_tb;

	localparam int READY_TIMEOUT = 20;
	localparam int DONE_TIMEOUT  = 100;
	localparam int NUM_DOUBLE    = 12;
	localparam int NUM_TRIPLE    = 8;
	localparam int PARITY_BITS   = `BCH_N - `BCH_K;

	// One table row with the data, the error pattern, its weight and the ack delay
	typedef struct packed {
		logic [`BCH_K-1:0] data;
		logic [`BCH_N-1:0] err_pat;
		logic [1:0]        weight;
		logic [3:0]        hold;
	} vector_t;

	logic                 clk;
	logic                 rst_n;
	logic                 start;
	logic [`BCH_N-1:0]    rx_word;
	logic                 ack_done;
	logic                 ready;
	logic                 done;
	bch_pkg::dec_result_t result;

	vector_t vectors [$];
	integer  seed;
	int      check_count;
	int      error_count;
	int      timeout_count;
	int      row_idx;

	bch_decoder bch_decoder_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.rx_word  (rx_word),
		.ack_done (ack_done),
		.ready    (ready),
		.done     (done),
		.result   (result)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference code arithmetic
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Bit i of the word is the coefficient of x^i, so this is word(x) mod g(x)
	function automatic logic [PARITY_BITS-1:0] gen_remainder(input logic [`BCH_N-1:0] word);
		logic [`BCH_N-1:0] rem;
		logic [`BCH_N-1:0] gen;
		rem = word;
		gen = '0;
		gen[PARITY_BITS:0] = `BCH_GEN_POLY;
		for (int i = `BCH_N - 1; i >= PARITY_BITS; i--) begin
			if (rem[i])
				rem = rem ^ (gen << (i - PARITY_BITS));
		end
		return rem[PARITY_BITS-1:0];
	endfunction

	// Systematic form puts the data in the top bits and the parity below
	function automatic logic [`BCH_N-1:0] encode_word(input logic [`BCH_K-1:0] data);
		logic [`BCH_N-1:0] shifted;
		shifted = {data, {PARITY_BITS{1'b0}}};
		return {data, gen_remainder(shifted)};
	endfunction

	function automatic int count_ones(input logic [`BCH_N-1:0] pat);
		int n;
		n = 0;
		for (int i = 0; i < `BCH_N; i++)
			n += pat[i];
		return n;
	endfunction

	task automatic random_pattern(input int weight, output logic [`BCH_N-1:0] pat);
		logic [31:0] raw;
		pat = '0;
		while (count_ones(pat) != weight) begin
			raw = $random(seed);
			pat = raw[`BCH_N-1:0];
		end
	endtask

	task automatic random_data(output logic [`BCH_K-1:0] data);
		logic [31:0] raw;
		raw = $random(seed);
		data = raw[`BCH_K-1:0];
	endtask

	task automatic add_vector(input logic [`BCH_K-1:0] data, input logic [`BCH_N-1:0] pat,
			input logic [1:0] weight, input logic [3:0] hold);
		vector_t v;
		v.data    = data;
		v.err_pat = pat;
		v.weight  = weight;
		v.hold    = hold;
		vectors.push_back(v);
	endtask

	task automatic build_vectors();
		logic [`BCH_K-1:0] data;
		logic [`BCH_N-1:0] pat;
		add_vector(7'h00, '0, 2'd0, 4'd0);
		add_vector(7'h7f, '0, 2'd0, 4'd0);
		// This one keeps ack_done low for a while
		add_vector(7'h2a, '0, 2'd0, 4'd6);
		for (int i = 0; i < `BCH_N; i++) begin
			random_data(data);
			add_vector(data, 15'b1 << i, 2'd1, (i == 7) ? 4'd3 : 4'd0);
		end
		for (int i = 0; i < NUM_DOUBLE; i++) begin
			random_data(data);
			random_pattern(2, pat);
			add_vector(data, pat, 2'd2, (i == 4) ? 4'd5 : 4'd0);
		end
		for (int i = 0; i < NUM_TRIPLE; i++) begin
			random_data(data);
			random_pattern(3, pat);
			add_vector(data, pat, 2'd3, 4'd0);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks and handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERR %s (row %0d) at %0t: got 0x%0h, expected 0x%0h",
				name, row_idx, $time, actual, expected);
		end
	endtask

	task automatic wait_ready(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < READY_TIMEOUT && !ok; n++) begin
			@(negedge clk);
			ok = (ready === 1'b1);
		end
		if (!ok) begin
			timeout_count++;
			$display("Timeout: ready stayed low for %0d cycles (row %0d)",
				READY_TIMEOUT, row_idx);
		end
	endtask

	task automatic wait_done(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < DONE_TIMEOUT && !ok; n++) begin
			@(negedge clk);
			ok = (done === 1'b1);
		end
		if (!ok) begin
			timeout_count++;
			$display("Timeout: done did not rise within %0d cycles (row %0d)",
				DONE_TIMEOUT, row_idx);
		end
	endtask

	task automatic check_result(input vector_t v, input logic [`BCH_N-1:0] coded,
			input logic [`BCH_N-1:0] word, input bch_pkg::dec_result_t res);
		bit fine;
		if (v.weight == 2'd3) begin
			// Past t the word is either flagged and left alone or moved onto another codeword
			fine = (res.uncorrectable && res.codeword == word) ||
				(gen_remainder(res.codeword) == '0);
			check_value("result (triple error)", fine, 1'b1);
		end else begin
			check_value("result.codeword", res.codeword, coded);
			check_value("result.data", res.data, v.data);
			check_value("result.err_count", res.err_count, v.weight);
			check_value("result.uncorrectable", res.uncorrectable, 1'b0);
		end
	endtask

	task automatic apply_row(input vector_t v);
		logic [`BCH_N-1:0]    coded;
		logic [`BCH_N-1:0]    word;
		bch_pkg::dec_result_t captured;
		bit                   ok;
		coded = encode_word(v.data);
		word  = coded ^ v.err_pat;
		wait_ready(ok);
		if (!ok)
			return;
		start   = 1'b1;
		rx_word = word;
		@(negedge clk);
		check_value("ready", ready, 1'b0);
		start = 1'b0;
		wait_done(ok);
		if (!ok)
			return;
		captured = result;
		check_result(v, coded, word, captured);
		for (int h = 0; h < v.hold; h++) begin
			@(negedge clk);
			check_value("ready", ready, 1'b0);
			check_value("done", done, 1'b1);
			check_value("result", result, captured);
		end
		ack_done = 1'b1;
		@(negedge clk);
		check_value("done", done, 1'b0);
		check_value("ready", ready, 1'b1);
		ack_done = 1'b0;
	endtask

	initial begin
		bit ok;
		seed          = 32'h3d3d7825;
		check_count   = 0;
		error_count   = 0;
		timeout_count = 0;
		row_idx       = -1;
		rst_n         = 1'b0;
		start         = 1'b0;
		rx_word       = '0;
		ack_done      = 1'b0;
		build_vectors();
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("done", done, 1'b0);
		rst_n = 1'b1;
		wait_ready(ok);
		if (ok)
			check_value("done", done, 1'b0);
		for (int i = 0; i < vectors.size() && timeout_count == 0; i++) begin
			row_idx = i;
			apply_row(vectors[i]);
		end
		$display("Rows: %0d, checks: %0d, mismatches: %0d, timeouts: %0d",
			vectors.size(), check_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
